/* Makefile */
VERILATOR ?= verilator
TOP       ?= lstmCellTb
FILELIST  ?= lstmCell.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* lstmCell.f */
+incdir+include
rtl/lstmPkg.sv
rtl/weightStore.sv
rtl/cellSequencer.sv
rtl/gateMac.sv
rtl/cellUpdate.sv
rtl/lstmCell.sv
test/lstmCellTb.sv

/* rtl/cellSequencer.sv */
`timescale 1ns/1ps

module cellSequencer import lstmPkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     newSample,
    output stepPhase phase,
    output colIndex  readCol
);

    stepPhase nextPhase;
    colIndex  colCount;
    logic     lastCol;

    assign lastCol = colCount == colIndex'(COL_COUNT - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= idle;
            colCount <= '0;
        end else begin
            phase <= nextPhase;
            if (phase == gateAccum) begin
                colCount <= colCount + 3'd1;
            end else begin
                colCount <= '0;
            end
        end
    end

    always_comb begin
        nextPhase = phase;
        case (phase)
            idle: begin
                // Pulses outside idle are dropped
                if (newSample) begin
                    nextPhase = gateLoad;
                end
            end
            gateLoad: begin
                nextPhase = gateAccum;
            end
            gateAccum: begin
                if (lastCol) begin
                    nextPhase = productZi;
                end
            end
            productZi: begin
                nextPhase = productCf;
            end
            productCf: begin
                nextPhase = productOh;
            end
            productOh: begin
                nextPhase = done;
            end
            done: begin
                nextPhase = idle;
            end
            default: begin
                nextPhase = idle;
            end
        endcase
    end

    // Bias column first so the sums start from the bias
    assign readCol = (phase == gateLoad) ? colIndex'(BIAS_COL) : colCount;

    colInBounds: assert property (
        @(posedge clock) disable iff (reset)
        (phase == gateAccum) |-> (readCol < colIndex'(COL_COUNT))
    );

endmodule

/* rtl/cellUpdate.sv */
`timescale 1ns/1ps

module cellUpdate import lstmPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  stepPhase    phase,
    input  weightColumn preact,
    output hiddenVector hiddenPrev,
    output logic        outputReady,
    output hiddenVector hiddenOut
);

    hiddenVector zAct;
    hiddenVector iAct;
    hiddenVector fAct;
    hiddenVector oAct;
    hiddenVector ziProd;
    hiddenVector cfProd;
    hiddenVector cellNext;
    hiddenVector cellState;

    always_comb begin
        for (int r = 0; r < HIDDEN_SZ; r++) begin
            zAct[r] = hardTanh(preact[0][r]);
            iAct[r] = hardSigmoid(preact[1][r]);
            fAct[r] = hardSigmoid(preact[2][r]);
            oAct[r] = hardSigmoid(preact[3][r]);
        end
    end

    // Gate sums settle at the end of productZi
    always_ff @(posedge clock) begin
        case (phase)
            productCf: begin
                for (int r = 0; r < HIDDEN_SZ; r++) begin
                    ziProd[r] <= fixMul(zAct[r], iAct[r]);
                    cfProd[r] <= fixMul(fAct[r], cellState[r]);
                end
            end
            productOh: begin
                for (int r = 0; r < HIDDEN_SZ; r++) begin
                    cellNext[r] <= ziProd[r] + cfProd[r];
                end
            end
            default: begin
            end
        endcase
    end

    // State commits only at the end of a step
    always_ff @(posedge clock) begin
        if (reset) begin
            hiddenOut <= '0;
            cellState <= '0;
            outputReady <= 1'b0;
        end else begin
            outputReady <= phase == done;
            if (phase == done) begin
                for (int r = 0; r < HIDDEN_SZ; r++) begin
                    hiddenOut[r] <= fixMul(oAct[r], hardTanh(cellNext[r]));
                end
                cellState <= cellNext;
            end
        end
    end

    assign hiddenPrev = hiddenOut;

    readyAfterDone: assert property (
        @(posedge clock) disable iff (reset)
        outputReady |-> ($past(phase, 2) == productOh) && (phase == idle)
    );

endmodule

/* rtl/gateMac.sv */
`timescale 1ns/1ps

module gateMac import lstmPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  stepPhase    phase,
    input  colIndex     readCol,
    input  weightColumn column,
    input  inputVector  inputVec,
    input  hiddenVector hiddenPrev,
    output weightColumn preact
);

    colIndex    colDelayed;
    logic       colValid;
    inputVector inputHeld;
    fixWord     operand;

    // Aligns with the registered read of the weight store
    always_ff @(posedge clock) begin
        if (reset) begin
            colDelayed <= '0;
            colValid <= 1'b0;
        end else begin
            colDelayed <= readCol;
            colValid <= (phase == gateLoad) || (phase == gateAccum);
        end
    end

    // Input as seen on the edge that starts the step
    always_ff @(posedge clock) begin
        if (phase == idle) begin
            inputHeld <= inputVec;
        end
    end

    // Columns 0 to 1 take the input, 2 to 5 the previous h
    always_comb begin
        operand = '0;
        for (int k = 0; k < INPUT_SZ; k++) begin
            if (colDelayed == colIndex'(k)) begin
                operand = inputHeld[k];
            end
        end
        for (int k = 0; k < HIDDEN_SZ; k++) begin
            if (colDelayed == colIndex'(INPUT_SZ + k)) begin
                operand = hiddenPrev[k];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (colValid) begin
            for (int g = 0; g < GATE_COUNT; g++) begin
                for (int r = 0; r < HIDDEN_SZ; r++) begin
                    if (colDelayed == colIndex'(BIAS_COL)) begin
                        preact[g][r] <= column[g][r];
                    end else begin
                        preact[g][r] <= preact[g][r] + fixMul(column[g][r], operand);
                    end
                end
            end
        end
    end

    biasFirst: assert property (
        @(posedge clock) disable iff (reset)
        (colValid && !$past(colValid)) |-> (colDelayed == colIndex'(BIAS_COL))
    );

endmodule

/* rtl/lstmCell.sv */
`timescale 1ns/1ps

module lstmCell import lstmPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  wbRequest    wbReq,
    output wbResponse   wbRsp,
    input  inputVector  inputVec,
    input  logic        newSample,
    output logic        outputReady,
    output hiddenVector hiddenOut
);

    stepPhase    phase;
    colIndex     readCol;
    weightColumn column;
    weightColumn preact;
    hiddenVector hiddenPrev;

    weightStore weights (
        .clock   (clock),
        .reset   (reset),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp),
        .readCol (readCol),
        .column  (column)
    );

    // Decode
    cellSequencer sequencer (
        .clock     (clock),
        .reset     (reset),
        .newSample (newSample),
        .phase     (phase),
        .readCol   (readCol)
    );

    // Execute
    gateMac mac (
        .clock      (clock),
        .reset      (reset),
        .phase      (phase),
        .readCol    (readCol),
        .column     (column),
        .inputVec   (inputVec),
        .hiddenPrev (hiddenPrev),
        .preact     (preact)
    );

    // Result
    cellUpdate update (
        .clock       (clock),
        .reset       (reset),
        .phase       (phase),
        .preact      (preact),
        .hiddenPrev  (hiddenPrev),
        .outputReady (outputReady),
        .hiddenOut   (hiddenOut)
    );

endmodule

/* rtl/lstmPkg.sv */
package lstmPkg;

    // Q6.11 fixed point
    localparam int QN = 6;
    localparam int QM = 11;
    localparam int WORD_W = QN + QM + 1;

    localparam int INPUT_SZ = 2;
    localparam int HIDDEN_SZ = 4;
    localparam int GATE_COUNT = 4;
    localparam int COL_COUNT = INPUT_SZ + HIDDEN_SZ;
    localparam int BIAS_COL = COL_COUNT;
    localparam int CELL_LATENCY = COL_COUNT + 5;

    typedef logic signed [WORD_W-1:0] fixWord;
    typedef logic [1:0] gateSel;
    typedef logic [1:0] rowIndex;
    typedef logic [2:0] colIndex;

    localparam fixWord ONE = 18'sd2048;
    localparam fixWord HALF = 18'sd1024;

    typedef fixWord [INPUT_SZ-1:0] inputVector;
    typedef fixWord [HIDDEN_SZ-1:0] hiddenVector;
    // Gate 0 is Z, then I, F and O
    typedef hiddenVector [GATE_COUNT-1:0] weightColumn;

    // Address is gate, row, column from the top bits down
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [6:0]  adr;
        logic [31:0] dat;
    } wbRequest;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbResponse;

    typedef enum logic [2:0] {
        idle,
        gateLoad,
        gateAccum,
        productZi,
        productCf,
        productOh,
        done
    } stepPhase;

    function automatic fixWord fixMul(fixWord a, fixWord b);
        logic signed [2*WORD_W-1:0] product;
        product = a * b;
        return fixWord'(product >>> QM);
    endfunction

    // Slope of one quarter through 0.5
    function automatic fixWord hardSigmoid(fixWord x);
        fixWord y;
        y = (x >>> 2) + HALF;
        if (y < 0) begin
            return '0;
        end else if (y > ONE) begin
            return ONE;
        end
        return y;
    endfunction

    function automatic fixWord hardTanh(fixWord x);
        if (x > ONE) begin
            return ONE;
        end else if (x < -ONE) begin
            return -ONE;
        end
        return x;
    endfunction

endpackage

/* rtl/weightStore.sv */
`timescale 1ns/1ps

module weightStore import lstmPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  wbRequest    wbReq,
    output wbResponse   wbRsp,
    input  colIndex     readCol,
    output weightColumn column
);

    // Columns 0 to 5 are weights, column 6 the bias
    fixWord mem [GATE_COUNT][HIDDEN_SZ][BIAS_COL+1];

    gateSel  reqGate;
    rowIndex reqRow;
    colIndex reqCol;
    logic    request;
    logic    accept;
    logic    served;
    logic    colInRange;
    fixWord  readWord;

    assign reqGate = wbReq.adr[6:5];
    assign reqRow = wbReq.adr[4:3];
    assign reqCol = wbReq.adr[2:0];
    assign request = wbReq.cyc && wbReq.stb;
    assign colInRange = reqCol <= colIndex'(BIAS_COL);

    // One ack per request, then wait for the request to drop
    assign accept = request && !served;

    // Column 7 is unmapped
    assign readWord = colInRange ? mem[reqGate][reqRow][reqCol] : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int g = 0; g < GATE_COUNT; g++) begin
                for (int r = 0; r < HIDDEN_SZ; r++) begin
                    for (int c = 0; c <= BIAS_COL; c++) begin
                        mem[g][r][c] <= '0;
                    end
                end
            end
            wbRsp <= '0;
            served <= 1'b0;
        end else begin
            wbRsp.ack <= accept;
            served <= request && (served || accept);
            if (accept) begin
                if (wbReq.we && colInRange) begin
                    mem[reqGate][reqRow][reqCol] <= wbReq.dat[WORD_W-1:0];
                end
                wbRsp.dat <= {{(32 - WORD_W){readWord[WORD_W-1]}}, readWord};
            end
        end
    end

    // Whole column across all gates and rows for the MAC
    always_ff @(posedge clock) begin
        for (int g = 0; g < GATE_COUNT; g++) begin
            for (int r = 0; r < HIDDEN_SZ; r++) begin
                if (readCol <= colIndex'(BIAS_COL)) begin
                    column[g][r] <= mem[g][r][readCol];
                end else begin
                    column[g][r] <= '0;
                end
            end
        end
    end

    ackSinglePulse: assert property (
        @(posedge clock) disable iff (reset)
        wbRsp.ack |=> !wbRsp.ack
    );

endmodule

/* include/lstmModel.svh */
`ifndef LSTM_MODEL_SVH
`define LSTM_MODEL_SVH

// Mirror of the weight store, bias in the last column
fixWord modelWeights [GATE_COUNT][HIDDEN_SZ][BIAS_COL+1];
fixWord modelH [HIDDEN_SZ];
fixWord modelC [HIDDEN_SZ];

function automatic fixWord modelMul(fixWord a, fixWord b);
    longint product;
    product = longint'(a) * longint'(b);
    return fixWord'(product >>> QM);
endfunction

function automatic fixWord modelSigmoid(fixWord x);
    int v;
    v = (int'(x) >>> 2) + 1024;
    if (v < 0) begin
        v = 0;
    end else if (v > 2048) begin
        v = 2048;
    end
    return fixWord'(v);
endfunction

function automatic fixWord modelTanh(fixWord x);
    int v;
    v = int'(x);
    if (v > 2048) begin
        v = 2048;
    end else if (v < -2048) begin
        v = -2048;
    end
    return fixWord'(v);
endfunction

function automatic void modelClearState();
    for (int r = 0; r < HIDDEN_SZ; r++) begin
        modelH[r] = '0;
        modelC[r] = '0;
    end
endfunction

// One time step, sums wrap at 18 bits like the hardware
function automatic void modelStep(inputVector x);
    fixWord pre [GATE_COUNT][HIDDEN_SZ];
    fixWord operand [COL_COUNT];
    fixWord cNew;
    for (int k = 0; k < INPUT_SZ; k++) begin
        operand[k] = x[k];
    end
    for (int k = 0; k < HIDDEN_SZ; k++) begin
        operand[INPUT_SZ + k] = modelH[k];
    end
    for (int g = 0; g < GATE_COUNT; g++) begin
        for (int r = 0; r < HIDDEN_SZ; r++) begin
            pre[g][r] = modelWeights[g][r][BIAS_COL];
            for (int k = 0; k < COL_COUNT; k++) begin
                pre[g][r] = pre[g][r] + modelMul(modelWeights[g][r][k], operand[k]);
            end
        end
    end
    for (int r = 0; r < HIDDEN_SZ; r++) begin
        cNew = modelMul(modelTanh(pre[0][r]), modelSigmoid(pre[1][r]))
            + modelMul(modelSigmoid(pre[2][r]), modelC[r]);
        modelC[r] = cNew;
        modelH[r] = modelMul(modelSigmoid(pre[3][r]), modelTanh(cNew));
    end
endfunction

`endif

/* test/lstmCellTb.sv */
`timescale 1ns/1ps

module lstmCellTb import lstmPkg::*; ();

    localparam logic [31:0] SEED = 32'he5de_8918;
    localparam int WB_TRANSFERS = 480;
    localparam int STEP_COUNT = 39;
    localparam int CYCLE_LIMIT = WB_TRANSFERS * 4 + STEP_COUNT * (CELL_LATENCY + 4) + 200;
    localparam int ACK_LIMIT = 8;

    logic        clock;
    logic        reset;
    wbRequest    wbReq;
    wbResponse   wbRsp;
    inputVector  inputVec;
    logic        newSample;
    logic        outputReady;
    hiddenVector hiddenOut;

    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testFailCount;
    int          cycleCount;
    logic [31:0] seedValue;

    `include "lstmModel.svh"

    lstmCell DUT (
        .clock       (clock),
        .reset       (reset),
        .wbReq       (wbReq),
        .wbRsp       (wbRsp),
        .inputVec    (inputVec),
        .newSample   (newSample),
        .outputReady (outputReady),
        .hiddenOut   (hiddenOut)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    function automatic logic [31:0] signExtend(fixWord value);
        return {{14{value[WORD_W-1]}}, value};
    endfunction

    // Uniform in -span..span-1
    function automatic fixWord randomFix(int span);
        int value;
        value = int'($urandom_range(2 * span - 1, 0)) - span;
        return fixWord'(value);
    endfunction

    function automatic inputVector randomInput(int span);
        inputVector x;
        for (int k = 0; k < INPUT_SZ; k++) begin
            x[k] = randomFix(span);
        end
        return x;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic noteFailure(input string what);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            testFailCount++;
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    // Starts and ends on a falling edge, one idle cycle between requests
    task automatic wbTransfer(input logic write, input logic [6:0] adr,
                              input logic [31:0] data, output logic [31:0] readData);
        int waited;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we = write;
        wbReq.adr = adr;
        wbReq.dat = data;
        @(negedge clock);
        waited = 1;
        while (!wbRsp.ack && waited < ACK_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!wbRsp.ack) begin
            noteFailure($sformatf("no Wishbone ack for address %h", adr));
        end else if (waited > 2) begin
            noteFailure($sformatf("Wishbone ack for address %h took %0d cycles", adr, waited));
        end
        readData = wbRsp.dat;
        wbReq = '0;
        @(negedge clock);
    endtask

    task automatic randomizeWeights(input int span);
        for (int g = 0; g < GATE_COUNT; g++) begin
            for (int r = 0; r < HIDDEN_SZ; r++) begin
                for (int c = 0; c <= BIAS_COL; c++) begin
                    modelWeights[g][r][c] = randomFix(span);
                end
            end
        end
    endtask

    task automatic loadWeights();
        logic [31:0] unused;
        for (int g = 0; g < GATE_COUNT; g++) begin
            for (int r = 0; r < HIDDEN_SZ; r++) begin
                for (int c = 0; c <= BIAS_COL; c++) begin
                    wbTransfer(1'b1, {gateSel'(g), rowIndex'(r), colIndex'(c)},
                               signExtend(modelWeights[g][r][c]), unused);
                end
            end
        end
    endtask

    task automatic checkHiddenZero();
        for (int r = 0; r < HIDDEN_SZ; r++) begin
            checkValue($sformatf("hiddenOut[%0d]", r), 32'd0, signExtend(hiddenOut[r]));
        end
    endtask

    // Extra pulses land in phases other than idle
    task automatic runStep(input inputVector x, input logic extraPulses);
        int edges;
        inputVec = x;
        newSample = 1'b1;
        @(negedge clock);
        newSample = 1'b0;
        edges = 0;
        while (!outputReady && edges < CELL_LATENCY + 4) begin
            @(negedge clock);
            edges++;
            newSample = extraPulses && (edges == 2 || edges == 5 || edges == 9);
        end
        modelStep(x);
        if (!outputReady) begin
            noteFailure("outputReady never rose during the step");
        end else begin
            checkValue("outputReady latency", 32'(CELL_LATENCY), 32'(edges));
            for (int r = 0; r < HIDDEN_SZ; r++) begin
                checkValue($sformatf("hiddenOut[%0d]", r), signExtend(modelH[r]),
                           signExtend(hiddenOut[r]));
            end
        end
        @(negedge clock);
        if (outputReady) begin
            noteFailure("outputReady stayed high for more than one cycle");
        end
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycleCount);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int          errorsBefore;
        logic [31:0] readData;
        logic        extraReady;
        reset = 1'b1;
        wbReq = '0;
        inputVec = '0;
        newSample = 1'b0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        testFailCount = 0;
        seedValue = $urandom(SEED);
        modelClearState();
        repeat (2) @(negedge clock);
        reset = 1'b0;

        errorsBefore = errorCount;
        randomizeWeights(512);
        for (int g = 0; g < GATE_COUNT; g++) begin
            for (int r = 0; r < HIDDEN_SZ; r++) begin
                for (int c = 0; c < 8; c++) begin
                    // Column 7 gets junk that must not stick
                    if (c <= BIAS_COL) begin
                        readData = signExtend(modelWeights[g][r][c]);
                    end else begin
                        readData = $urandom;
                    end
                    wbTransfer(1'b1, {gateSel'(g), rowIndex'(r), colIndex'(c)},
                               readData, readData);
                end
            end
        end
        for (int g = 0; g < GATE_COUNT; g++) begin
            for (int r = 0; r < HIDDEN_SZ; r++) begin
                for (int c = 0; c < 8; c++) begin
                    wbTransfer(1'b0, {gateSel'(g), rowIndex'(r), colIndex'(c)},
                               32'd0, readData);
                    if (c <= BIAS_COL) begin
                        checkValue($sformatf("wbRsp.dat[%0d][%0d][%0d]", g, r, c),
                                   signExtend(modelWeights[g][r][c]), readData);
                    end else begin
                        checkValue($sformatf("wbRsp.dat[%0d][%0d][%0d]", g, r, c),
                                   32'd0, readData);
                    end
                end
            end
        end
        finishTest("weight write and readback", errorsBefore);

        errorsBefore = errorCount;
        checkHiddenZero();
        runStep(randomInput(2048), 1'b0);
        finishTest("first step latency and value", errorsBefore);

        errorsBefore = errorCount;
        repeat (20) runStep(randomInput(2048), 1'b0);
        finishTest("twenty step recurrence", errorsBefore);

        errorsBefore = errorCount;
        repeat (4) begin
            runStep(randomInput(2048), 1'b1);
            extraReady = 1'b0;
            repeat (CELL_LATENCY + 1) begin
                @(negedge clock);
                extraReady = extraReady || outputReady;
            end
            if (extraReady) begin
                noteFailure("an ignored newSample pulse produced another outputReady");
            end
        end
        finishTest("newSample during a step", errorsBefore);

        errorsBefore = errorCount;
        randomizeWeights(8192);
        loadWeights();
        repeat (8) runStep(randomInput(4096), 1'b0);
        finishTest("saturating activations", errorsBefore);

        errorsBefore = errorCount;
        inputVec = randomInput(2048);
        newSample = 1'b1;
        @(negedge clock);
        newSample = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        extraReady = 1'b0;
        repeat (CELL_LATENCY + 2) begin
            @(negedge clock);
            extraReady = extraReady || outputReady;
        end
        if (extraReady) begin
            noteFailure("outputReady rose after a reset during a step");
        end
        checkHiddenZero();
        modelClearState();
        loadWeights();
        runStep(randomInput(2048), 1'b0);
        finishTest("reset during a step", errorsBefore);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, testFailCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
